/* rtl/u2_ctrl_pkg.sv */
// Board control plane shared definitions
// Setting addresses, vector types and control structs
`default_nettype none

package u2_ctrl_pkg;

   // Settings bus words
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // One settings-bus write, valid while stb is high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } setting_t;

   // Clock generator control, data bits 4:0
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   // Bit 0 phy, 1 serdes link, 2 clk status, 3 pps, 4 one-shot, 5 periodic
   typedef logic [7:0] irq_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   ////////////////////////////////////////////////////////////////////////////
   // Setting register map
   localparam set_addr_t SR_CLOCK     = 8'd0;
   localparam set_addr_t SR_SERDES    = 8'd1;
   localparam set_addr_t SR_ADC       = 8'd2;
   localparam set_addr_t SR_LED_SW    = 8'd3;
   localparam set_addr_t SR_PHY       = 8'd4;
   localparam set_addr_t SR_LED_SRC   = 8'd8;
   localparam set_addr_t SR_IRQ_MASK  = 8'd10;
   localparam set_addr_t SR_IRQ_CLEAR = 8'd11;
   // Three registers from here
   localparam set_addr_t SR_TIME64    = 8'd192;
   // Two registers from here
   localparam set_addr_t SR_SIMTIMER  = 8'd198;

   localparam set_data_t TICKS_PER_SEC_DEFAULT = 32'd100000000;

endpackage

`default_nettype wire

/* rtl/board_ctrl_regs.sv */
// Board control setting registers
// Clock, SERDES, ADC, PHY reset and LED registers with LED source mux
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_regs (
   input  wire                       dsp_clk,
   input  wire                       wb_rst,
   input  u2_ctrl_pkg::setting_t     set_i,
   input  wire                       clk_status_i,
   input  wire                       serdes_link_up_i,
   output u2_ctrl_pkg::clock_ctrl_t  clock_ctrl_o,
   output u2_ctrl_pkg::serdes_ctrl_t serdes_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                      phy_reset_n_o,
   output u2_ctrl_pkg::led_t         leds_o
);

   u2_ctrl_pkg::clock_ctrl_t  clock_q;
   u2_ctrl_pkg::serdes_ctrl_t serdes_q;
   u2_ctrl_pkg::adc_ctrl_t    adc_q;
   u2_ctrl_pkg::led_t         led_sw_q;
   u2_ctrl_pkg::led_t         led_src_q;
   u2_ctrl_pkg::led_t         led_hw;
   logic                      phy_reset_q;

   ////////////////////////////////////////////////////////////////////////////
   // Register writes, one address each
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         led_sw_q    <= '0;
         led_src_q   <= '0;
         phy_reset_q <= 1'b0;
      end else if (set_i.stb) begin
         case (set_i.addr)
            u2_ctrl_pkg::SR_CLOCK:   clock_q     <= set_i.data[4:0];
            u2_ctrl_pkg::SR_SERDES:  serdes_q    <= set_i.data[3:0];
            u2_ctrl_pkg::SR_ADC:     adc_q       <= set_i.data[3:0];
            u2_ctrl_pkg::SR_LED_SW:  led_sw_q    <= set_i.data[7:0];
            u2_ctrl_pkg::SR_PHY:     phy_reset_q <= set_i.data[0];
            u2_ctrl_pkg::SR_LED_SRC: led_src_q   <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   assign clock_ctrl_o  = clock_q;
   assign serdes_ctrl_o = serdes_q;
   assign adc_ctrl_o    = adc_q;
   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset_q;

   ////////////////////////////////////////////////////////////////////////////
   // LEDs, source bit 1 picks hardware, 0 picks software
   assign led_hw = {6'b000000, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

/* rtl/simple_timer.sv */
// One-shot and periodic countdown timers with interrupt pulses
`timescale 1ns/1ps
`default_nettype none

module simple_timer #(
   parameter u2_ctrl_pkg::set_addr_t BASE = u2_ctrl_pkg::SR_SIMTIMER
) (
   input  wire                   dsp_clk,
   input  wire                   wb_rst,
   input  u2_ctrl_pkg::setting_t set_i,
   output logic                  onetime_int_o,
   output logic                  periodic_int_o
);

   localparam u2_ctrl_pkg::set_addr_t ADDR_ONETIME  = BASE;
   localparam u2_ctrl_pkg::set_addr_t ADDR_PERIODIC = BASE + 8'd1;

   typedef enum logic {ST_IDLE, ST_COUNT} oneshot_state_t;

   oneshot_state_t            state;
   u2_ctrl_pkg::set_data_t    onetime_cnt;
   u2_ctrl_pkg::set_data_t    period;
   u2_ctrl_pkg::set_data_t    periodic_cnt;
   logic                      wr_onetime;
   logic                      wr_periodic;

   assign wr_onetime  = set_i.stb && (set_i.addr == ADDR_ONETIME);
   assign wr_periodic = set_i.stb && (set_i.addr == ADDR_PERIODIC);

   // One-shot, pulse N edges after the write, zero cancels
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state         <= ST_IDLE;
         onetime_cnt   <= '0;
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= 1'b0;
         if (wr_onetime) begin
            onetime_cnt <= set_i.data;
            if (set_i.data != '0)
               state <= ST_COUNT;
            else
               state <= ST_IDLE;
         end else if (state == ST_COUNT) begin
            if (onetime_cnt == 32'd1) begin
               onetime_int_o <= 1'b1;
               state         <= ST_IDLE;
            end else begin
               onetime_cnt <= onetime_cnt - 32'd1;
            end
         end
      end
   end

   // Periodic, reloads from the stored period; period 0 stops it
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         period         <= '0;
         periodic_cnt   <= '0;
         periodic_int_o <= 1'b0;
      end else begin
         periodic_int_o <= 1'b0;
         if (wr_periodic) begin
            period       <= set_i.data;
            periodic_cnt <= set_i.data;
         end else if (period != '0) begin
            if (periodic_cnt == 32'd1) begin
               periodic_int_o <= 1'b1;
               periodic_cnt   <= period;
            end else begin
               periodic_cnt <= periodic_cnt - 32'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/vita_time.sv */
// VITA seconds and ticks time counter
// PPS synchronizer, immediate or PPS-armed load, PPS interrupt
`timescale 1ns/1ps
`default_nettype none

module vita_time #(
   parameter u2_ctrl_pkg::set_addr_t BASE          = u2_ctrl_pkg::SR_TIME64,
   parameter u2_ctrl_pkg::set_data_t TICKS_PER_SEC = u2_ctrl_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  wire                     dsp_clk,
   input  wire                     wb_rst,
   input  u2_ctrl_pkg::setting_t   set_i,
   input  wire                     pps_i,
   output u2_ctrl_pkg::vita_time_t vita_time_o,
   output logic                    pps_int_o
);

   localparam u2_ctrl_pkg::set_addr_t ADDR_SECS  = BASE;
   localparam u2_ctrl_pkg::set_addr_t ADDR_TICKS = BASE + 8'd1;
   localparam u2_ctrl_pkg::set_addr_t ADDR_CTRL  = BASE + 8'd2;

   typedef enum logic {LD_IDLE, LD_ARMED} load_state_t;

   load_state_t             load_state;
   u2_ctrl_pkg::vita_time_t pending;
   u2_ctrl_pkg::vita_time_t time_q;
   logic                    pps_meta;
   logic                    pps_sync;
   logic                    pps_prev;
   logic                    pps_rise;
   logic                    wr_ctrl;
   logic                    load_now;

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_meta  <= 1'b0;
         pps_sync  <= 1'b0;
         pps_prev  <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_meta  <= pps_i;
         pps_sync  <= pps_meta;
         pps_prev  <= pps_sync;
         pps_int_o <= pps_rise;
      end
   end

   assign pps_rise = pps_sync & ~pps_prev;

   // Pending time words
   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && (set_i.addr == ADDR_SECS))
         pending.secs <= set_i.data;
      if (set_i.stb && (set_i.addr == ADDR_TICKS))
         pending.ticks <= set_i.data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Load control, bit 0 set loads now, clear arms for the next PPS
   assign wr_ctrl  = set_i.stb && (set_i.addr == ADDR_CTRL);
   assign load_now = (wr_ctrl && set_i.data[0]) || ((load_state == LD_ARMED) && pps_rise);

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         load_state <= LD_IDLE;
      end else if (wr_ctrl) begin
         if (set_i.data[0])
            load_state <= LD_IDLE;
         else
            load_state <= LD_ARMED;
      end else if ((load_state == LD_ARMED) && pps_rise) begin
         load_state <= LD_IDLE;
      end
   end

   // Tick counter with carry into seconds
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         time_q <= '0;
      end else if (load_now) begin
         time_q <= pending;
      end else if (time_q.ticks == (TICKS_PER_SEC - 32'd1)) begin
         time_q.ticks <= '0;
         time_q.secs  <= time_q.secs + 32'd1;
      end else begin
         time_q.ticks <= time_q.ticks + 32'd1;
      end
   end

   assign vita_time_o = time_q;

endmodule

`default_nettype wire

/* rtl/interrupt_ctrl.sv */
// Interrupt controller
// Edge-latched pending bits, mask, clear and processor interrupt
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl (
   input  wire                   dsp_clk,
   input  wire                   wb_rst,
   input  u2_ctrl_pkg::setting_t set_i,
   input  u2_ctrl_pkg::irq_t     irq_i,
   output u2_ctrl_pkg::irq_t     irq_pending_o,
   output logic                  proc_int_o
);

   u2_ctrl_pkg::irq_t irq_prev;
   u2_ctrl_pkg::irq_t irq_rise;
   u2_ctrl_pkg::irq_t clear_bits;
   u2_ctrl_pkg::irq_t pending_q;
   u2_ctrl_pkg::irq_t mask_q;
   logic              wr_clear;
   logic              wr_mask;

   assign wr_clear = set_i.stb && (set_i.addr == u2_ctrl_pkg::SR_IRQ_CLEAR);
   assign wr_mask  = set_i.stb && (set_i.addr == u2_ctrl_pkg::SR_IRQ_MASK);

   assign irq_rise   = irq_i & ~irq_prev;
   assign clear_bits = wr_clear ? set_i.data[7:0] : '0;

   ////////////////////////////////////////////////////////////////////////////
   // Pending, a new edge wins over a clear in the same cycle
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         irq_prev  <= '0;
         pending_q <= '0;
         mask_q    <= '0;
      end else begin
         irq_prev  <= irq_i;
         pending_q <= (pending_q & ~clear_bits) | irq_rise;
         if (wr_mask)
            mask_q <= set_i.data[7:0];
      end
   end

   assign irq_pending_o = pending_q;
   assign proc_int_o    = |(pending_q & mask_q);

endmodule

`default_nettype wire

/* rtl/u2_ctrl_core.sv */
// Board control plane top level
// Settings bus fan-out, interrupt source assembly, block instances
`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_core #(
   parameter u2_ctrl_pkg::set_data_t TICKS_PER_SEC = u2_ctrl_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  wire                       dsp_clk,
   input  wire                       wb_rst,
   input  u2_ctrl_pkg::setting_t     set_i,
   input  wire                       pps_i,
   input  wire                       clk_status_i,
   input  wire                       serdes_link_up_i,
   input  wire                       phy_int_n_i,
   output u2_ctrl_pkg::clock_ctrl_t  clock_ctrl_o,
   output u2_ctrl_pkg::serdes_ctrl_t serdes_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                      phy_reset_n_o,
   output u2_ctrl_pkg::led_t         leds_o,
   output u2_ctrl_pkg::vita_time_t   vita_time_o,
   output u2_ctrl_pkg::irq_t         irq_pending_o,
   output logic                      proc_int_o
);

   logic              onetime_int;
   logic              periodic_int;
   logic              pps_int;
   u2_ctrl_pkg::irq_t irq;

   board_ctrl_regs board_ctrl_regs0 (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_i            (set_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ctrl_o     (clock_ctrl_o),
      .serdes_ctrl_o    (serdes_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o)
   );

   simple_timer #(
      .BASE (u2_ctrl_pkg::SR_SIMTIMER)
   ) simple_timer0 (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .set_i          (set_i),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   vita_time #(
      .BASE          (u2_ctrl_pkg::SR_TIME64),
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) vita_time0 (
      .dsp_clk     (dsp_clk),
      .wb_rst      (wb_rst),
      .set_i       (set_i),
      .pps_i       (pps_i),
      .vita_time_o (vita_time_o),
      .pps_int_o   (pps_int)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Interrupt sources, bits 7:6 reserved
   assign irq = {2'b00, periodic_int, onetime_int, pps_int,
                 clk_status_i, serdes_link_up_i, ~phy_int_n_i};

   interrupt_ctrl interrupt_ctrl0 (
      .dsp_clk       (dsp_clk),
      .wb_rst        (wb_rst),
      .set_i         (set_i),
      .irq_i         (irq),
      .irq_pending_o (irq_pending_o),
      .proc_int_o    (proc_int_o)
   );

endmodule

`default_nettype wire

/* tb/u2_ctrl_core_tb.sv */
// Testbench for the board control plane top level
// Stimulus and expected values come from the tests file, typed compare tasks
`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_core_tb;

   localparam u2_ctrl_pkg::set_data_t TICKS_PER_SEC = 32'd10;

   logic                      dsp_clk;
   logic                      wb_rst;
   u2_ctrl_pkg::setting_t     set;
   logic                      pps;
   logic                      clk_status;
   logic                      serdes_link_up;
   logic                      phy_int_n;
   u2_ctrl_pkg::clock_ctrl_t  clock_ctrl;
   u2_ctrl_pkg::serdes_ctrl_t serdes_ctrl;
   u2_ctrl_pkg::adc_ctrl_t    adc_ctrl;
   logic                      phy_reset_n;
   u2_ctrl_pkg::led_t         leds;
   u2_ctrl_pkg::vita_time_t   vita_time;
   u2_ctrl_pkg::irq_t         irq_pending;
   logic                      proc_int;

   int     check_cnt;
   int     mismatch_cnt;
   int     timeout_cnt;
   int     other_cnt;
   integer seed;
   integer fd;
   logic   abort;
   string  line;
   string  cmd;

   u2_ctrl_core #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) dut0 (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_i            (set),
      .pps_i            (pps),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .phy_int_n_i      (phy_int_n),
      .clock_ctrl_o     (clock_ctrl),
      .serdes_ctrl_o    (serdes_ctrl),
      .adc_ctrl_o       (adc_ctrl),
      .phy_reset_n_o    (phy_reset_n),
      .leds_o           (leds),
      .vita_time_o      (vita_time),
      .irq_pending_o    (irq_pending),
      .proc_int_o       (proc_int)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #5 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus and pin drivers, all changes land 1 ns after the rising edge
   task automatic step_clock();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic write_setting(input u2_ctrl_pkg::set_addr_t addr,
                                input u2_ctrl_pkg::set_data_t data);
      set.stb  = 1'b1;
      set.addr = addr;
      set.data = data;
      step_clock();
      set.stb  = 1'b0;
   endtask

   task automatic pulse_pps();
      pps = 1'b1;
      step_clock();
      pps = 1'b0;
   endtask

   task automatic report_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
      mismatch_cnt++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   task automatic check_clock_ctrl(input u2_ctrl_pkg::clock_ctrl_t got,
                                   input u2_ctrl_pkg::clock_ctrl_t exp);
      check_cnt++;
      if (got !== exp)
         report_mismatch("clock_ctrl", 64'(got), 64'(exp));
   endtask

   task automatic check_serdes_ctrl(input u2_ctrl_pkg::serdes_ctrl_t got,
                                    input u2_ctrl_pkg::serdes_ctrl_t exp);
      check_cnt++;
      if (got !== exp)
         report_mismatch("serdes_ctrl", 64'(got), 64'(exp));
   endtask

   task automatic check_adc_ctrl(input u2_ctrl_pkg::adc_ctrl_t got,
                                 input u2_ctrl_pkg::adc_ctrl_t exp);
      check_cnt++;
      if (got !== exp)
         report_mismatch("adc_ctrl", 64'(got), 64'(exp));
   endtask

   task automatic check_phy_reset(input logic got, input logic exp);
      check_cnt++;
      if (got !== exp)
         report_mismatch("phy_reset_n", 64'(got), 64'(exp));
   endtask

   task automatic check_leds(input u2_ctrl_pkg::led_t got, input u2_ctrl_pkg::led_t exp);
      check_cnt++;
      if (got !== exp)
         report_mismatch("leds", 64'(got), 64'(exp));
   endtask

   task automatic check_time(input u2_ctrl_pkg::vita_time_t got,
                             input u2_ctrl_pkg::vita_time_t exp);
      check_cnt++;
      if (got !== exp)
         report_mismatch("vita_time secs:ticks", got, exp);
   endtask

   task automatic check_irq(input u2_ctrl_pkg::irq_t got, input u2_ctrl_pkg::irq_t exp,
                            input logic got_int, input logic exp_int);
      check_cnt++;
      if (got !== exp || got_int !== exp_int)
         report_mismatch("irq_pending:proc_int", 64'({got, got_int}),
                         64'({exp, exp_int}));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Waits on a pending bit, never earlier than min_cycles
   task automatic wait_irq_bit(input logic [2:0] bit_idx, input int limit,
                               input int min_cycles);
      int cycles;
      cycles = 0;
      while (irq_pending[bit_idx] !== 1'b1 && cycles < limit) begin
         step_clock();
         cycles++;
      end
      check_cnt++;
      if (irq_pending[bit_idx] !== 1'b1) begin
         $display("Timeout: pending bit %0d did not set within %0d cycles", bit_idx, limit);
         timeout_cnt++;
         abort = 1'b1;
      end else if (cycles < min_cycles) begin
         $display("Mismatch at %0t: pending bit %0d set after %0d cycles, expected %0d or more",
                  $time, bit_idx, cycles, min_cycles);
         mismatch_cnt++;
      end
   endtask

   // Random software LEDs and source mask against the given hardware inputs
   task automatic random_leds(input logic cs, input logic lu);
      logic [31:0]       sw_word;
      logic [31:0]       src_word;
      u2_ctrl_pkg::led_t hw;
      u2_ctrl_pkg::led_t exp;
      sw_word        = $random(seed);
      src_word       = $random(seed);
      clk_status     = cs;
      serdes_link_up = lu;
      write_setting(u2_ctrl_pkg::SR_LED_SW, sw_word);
      write_setting(u2_ctrl_pkg::SR_LED_SRC, src_word);
      hw = {6'b000000, cs, lu};
      for (int i = 0; i < 8; i++)
         exp[i] = src_word[i] ? hw[i] : sw_word[i];
      check_leds(leds, exp);
   endtask

   task automatic run_command(input string text, input string op);
      string       word;
      string       kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      a = '0;
      b = '0;
      c = '0;
      word = "";
      kind = "";
      if (op == "check") begin
         void'($sscanf(text, "%s %s %h %h", word, kind, a, b));
         if (kind == "clock")        check_clock_ctrl(clock_ctrl, a[4:0]);
         else if (kind == "serdes")  check_serdes_ctrl(serdes_ctrl, a[3:0]);
         else if (kind == "adc")     check_adc_ctrl(adc_ctrl, a[3:0]);
         else if (kind == "phy")     check_phy_reset(phy_reset_n, a[0]);
         else if (kind == "leds")    check_leds(leds, a[7:0]);
         else if (kind == "time")    check_time(vita_time, {a, b});
         else if (kind == "irq")     check_irq(irq_pending, a[7:0], proc_int, b[0]);
         else begin
            $display("Unknown check kind in the tests file: %s", kind);
            other_cnt++;
         end
      end else begin
         void'($sscanf(text, "%s %h %h %h", word, a, b, c));
         if (op == "write")       write_setting(a[7:0], b);
         else if (op == "idle")   repeat (a) step_clock();
         else if (op == "pps")    pulse_pps();
         else if (op == "rand")   random_leds(a[0], b[0]);
         else if (op == "wait")   wait_irq_bit(a[2:0], b, c);
         else if (op == "board") begin
            clk_status     = a[0];
            serdes_link_up = b[0];
            phy_int_n      = c[0];
         end else begin
            $display("Unknown command in the tests file: %s", op);
            other_cnt++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reset, then one command per line until the end of the file
   initial begin
      set            = '0;
      pps            = 1'b0;
      clk_status     = 1'b0;
      serdes_link_up = 1'b0;
      phy_int_n      = 1'b1;
      wb_rst         = 1'b1;
      seed           = 32'hfcf3;
      check_cnt      = 0;
      mismatch_cnt   = 0;
      timeout_cnt    = 0;
      other_cnt      = 0;
      abort          = 1'b0;
      repeat (3) @(posedge dsp_clk);
      #1;
      wb_rst = 1'b0;

      fd = $fopen("tb/u2_ctrl_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the tests file tb/u2_ctrl_tests.txt");
         other_cnt++;
      end else begin
         while (!abort && !$feof(fd)) begin
            line = "";
            cmd  = "";
            if ($fgets(line, fd) != 0 && $sscanf(line, "%s", cmd) == 1
                && cmd.getc(0) != "#")
               run_command(line, cmd);
         end
         $fclose(fd);
      end

      $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d other errors",
               check_cnt, mismatch_cnt, timeout_cnt, other_cnt);
      if (mismatch_cnt == 0 && timeout_cnt == 0 && other_cnt == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/u2_ctrl_tests.txt */
# Columns: command, then hex arguments
# write ADDR DATA | idle N | pps | board CLK_STATUS LINK_UP PHY_INT_N | rand CLK_STATUS LINK_UP
# check KIND VALUE [VALUE2] | wait IRQ_BIT TIMEOUT MIN_CYCLES
check time 0 0
check clock 0
check serdes 0
check adc 0
check leds 0
check phy 1
write 0 1b
check clock 1b
write 1 a
check serdes a
write 2 5
check adc 5
write 4 1
check phy 0
rand 0 0
rand 1 0
rand 0 1
rand 1 1
write c0 5
write c1 7
write c2 1
idle 5
check time 6 2
write c0 20
write c1 3
write c2 0
idle 3
check time 6 8
pps
wait 3 8 0
check time 20 4
board 0 0 1
write b ff
check irq 0 0
write c6 14
wait 4 20 13
check irq 10 0
write a 10
check irq 10 1
write b 10
check irq 0 0
write c7 8
wait 5 10 7
write b 20
check irq 0 0
wait 5 10 0
write c7 0
check irq 20 0
write a 20
check irq 20 1
board 1 0 0
idle 1
check irq 25 1
write b 21
check irq 4 0

/* u2_ctrl_core.f */
rtl/u2_ctrl_pkg.sv
rtl/board_ctrl_regs.sv
rtl/simple_timer.sv
rtl/vita_time.sv
rtl/interrupt_ctrl.sv
rtl/u2_ctrl_core.sv
tb/u2_ctrl_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module u2_ctrl_core_tb \
   -f u2_ctrl_core.f || { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vu2_ctrl_core_tb)
echo "$out"

echo "$out" | grep -qx "Everything OK" && echo "Simulation passed" || \
   { echo "Simulation failed"; exit 1; }
